//--- source/soc_map_pkg.sv
// SoC address map, Wishbone bus types, reset hold time and interrupt lines
package soc_map_pkg;

	// ------------------------------------------------------------
	// Wishbone bus widths
	// ------------------------------------------------------------
	typedef logic [31:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;
	typedef logic [3:0]  wb_sel_t;

	// Region codes, bit 31 excluded
	// Boot memory at 0x00000000, compared on bits 30..28
	localparam logic [2:0] REGION_BOOT = 3'b000;
	// CSR bridge at 0x60000000, compared on bits 30..29
	localparam logic [1:0] REGION_CSR = 2'b11;

	// Upper address bits that must be zero for a null-pointer hit
	localparam int LOCK_TOP_BITS = 14;

	// Boot memory of 256 words
	localparam int RAM_ADDR_WIDTH = 8;
	typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;

	// Reset hold counter, kept short
	typedef logic [7:0] rst_cnt_t;
	localparam rst_cnt_t RST_HOLD_CYCLES = 8'd200;

	// Interrupt vector layout
	localparam int IRQ_GPIO = 0;
	localparam int IRQ_TIMER = 1;
	localparam int NUM_IRQ = 2;

endpackage

//--- source/soc_csr_pkg.sv
// CSR bus address layout and system controller register map
package soc_csr_pkg;

	// CSR word address is bus address bits 15..2
	typedef logic [13:0] csr_addr_t;
	// Upper four bits pick the bank
	typedef logic [3:0]  csr_bank_t;
	// Lower ten bits pick the register
	typedef logic [9:0]  csr_reg_t;

	localparam csr_bank_t BANK_SYSCTL = 4'd1;
	localparam csr_bank_t BANK_TIMER = 4'd2;

	// GPIO bank
	localparam csr_reg_t REG_GPIO_IN = 10'd0;
	localparam csr_reg_t REG_GPIO_OUT = 10'd1;
	localparam csr_reg_t REG_GPIO_IRQ_EN = 10'd2;
	localparam csr_reg_t REG_BUS_ERR_EN = 10'd3;
	localparam csr_reg_t REG_HARD_RESET = 10'd4;

	// Timer bank
	localparam csr_reg_t REG_TMR_CTRL = 10'd0;
	localparam csr_reg_t REG_TMR_COMPARE = 10'd1;
	localparam csr_reg_t REG_TMR_COUNTER = 10'd2;

	// Timer control bits
	localparam int TMR_CTRL_EN = 0;
	localparam int TMR_CTRL_AUTORELOAD = 1;

	// Board GPIO
	localparam int NUM_BTN = 3;
	localparam int NUM_LED = 2;

endpackage

//--- source/wb_slave_if.sv
// Wishbone slave link between the address decoder and one slave
`timescale 1ns/1ps

interface wb_slave_if;
	import soc_map_pkg::*;

	wb_addr_t adr;
	wb_data_t dat_w;
	wb_data_t dat_r;
	wb_sel_t  sel;
	logic     we;
	logic     cyc;
	logic     stb;
	logic     ack;

	// Decoder side, forwards the master request
	modport decoder (
		output adr, dat_w, sel, we, cyc, stb,
		input  dat_r, ack
	);

	// Slave side
	modport slave (
		input  adr, dat_w, sel, we, cyc, stb,
		output dat_r, ack
	);

endinterface

//--- source/reset_gen.sv
// Reset generator combining trigger sources into a held system reset
`timescale 1ns/1ps

module reset_gen (
	input  logic                           sys_clk,
	input  logic                           trigger_reset,
	input  logic [soc_csr_pkg::NUM_BTN-1:0] btn_i,
	input  logic                           hard_reset_i,
	output logic                           sys_rst_o
);
	import soc_map_pkg::*;

	logic     trigger_q;
	rst_cnt_t hold_cnt;

	// ------------------------------------------------------------
	// Trigger register and hold counter
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		// External pin, all buttons down, or software request
		trigger_q <= trigger_reset | hard_reset_i | (&btn_i);
		// Reload on each trigger, then count down to zero
		if (trigger_q)
			hold_cnt <= RST_HOLD_CYCLES;
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	// Trigger register covers the cycle before the counter loads
	assign sys_rst_o = trigger_q | (hold_cnt != '0);

endmodule

//--- source/wb_decoder.sv
// Wishbone address decoder with unmapped responder and bus-error flag
`timescale 1ns/1ps

module wb_decoder (
	input  logic                  sys_clk,
	input  logic                  sys_rst_i,
	input  soc_map_pkg::wb_addr_t wb_adr_i,
	input  soc_map_pkg::wb_data_t wb_dat_i,
	input  soc_map_pkg::wb_sel_t  wb_sel_i,
	input  logic                  wb_we_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  bus_err_en_i,
	output soc_map_pkg::wb_data_t wb_dat_o,
	output logic                  wb_ack_o,
	output logic                  wb_err_o,
	wb_slave_if.decoder           ram_o,
	wb_slave_if.decoder           csr_o
);
	import soc_map_pkg::*;

	logic sel_boot;
	logic sel_csr;
	logic sel_none;
	logic none_ack;
	logic lock_q;

	// ------------------------------------------------------------
	// Region select
	// ------------------------------------------------------------
	// Bit 31 left out, shadow region aliases the normal one
	assign sel_boot = wb_adr_i[30 -: $bits(REGION_BOOT)] == REGION_BOOT;
	assign sel_csr = wb_adr_i[30 -: $bits(REGION_CSR)] == REGION_CSR;
	assign sel_none = !sel_boot && !sel_csr;

	// Shared request lines, strobes to the selected slave only
	assign ram_o.adr = wb_adr_i;
	assign ram_o.dat_w = wb_dat_i;
	assign ram_o.sel = wb_sel_i;
	assign ram_o.we = wb_we_i;
	assign ram_o.cyc = wb_cyc_i & sel_boot;
	assign ram_o.stb = wb_stb_i & sel_boot;

	assign csr_o.adr = wb_adr_i;
	assign csr_o.dat_w = wb_dat_i;
	assign csr_o.sel = wb_sel_i;
	assign csr_o.we = wb_we_i;
	assign csr_o.cyc = wb_cyc_i & sel_csr;
	assign csr_o.stb = wb_stb_i & sel_csr;

	// Nothing mapped here, answer after one cycle
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			none_ack <= 1'b0;
		else
			none_ack <= wb_cyc_i & wb_stb_i & sel_none & ~none_ack;
	end

	// Read data back to the master, zero when unmapped
	always_comb begin
		if (sel_boot)
			wb_dat_o = ram_o.dat_r;
		else if (sel_csr)
			wb_dat_o = csr_o.dat_r;
		else
			wb_dat_o = '0;
	end

	assign wb_ack_o = ram_o.ack | csr_o.ack | none_ack;

	// ------------------------------------------------------------
	// Null-pointer area check
	// ------------------------------------------------------------
	// Address is held until ack, so last cycle's test is still valid
	always_ff @(posedge sys_clk)
		lock_q <= wb_adr_i[$bits(wb_addr_t)-1 -: LOCK_TOP_BITS] == '0;

	// Raised together with ack
	assign wb_err_o = lock_q & bus_err_en_i & wb_ack_o;

endmodule

//--- source/boot_ram.sv
// On-chip boot memory with byte-lane writes on a Wishbone slave port
`timescale 1ns/1ps

module boot_ram (
	input  logic      sys_clk,
	input  logic      sys_rst_i,
	wb_slave_if.slave bus_i
);
	import soc_map_pkg::*;

	wb_data_t  mem [2**RAM_ADDR_WIDTH];
	ram_addr_t word_idx;
	logic      ack_q;

	// Word index from bits 9..2
	assign word_idx = bus_i.adr[RAM_ADDR_WIDTH+1:2];

	// Storage and registered read port
	always_ff @(posedge sys_clk) begin
		// Write once per access, ack cycle excluded
		if (bus_i.cyc && bus_i.stb && bus_i.we && !ack_q) begin
			for (int i = 0; i < $bits(wb_sel_t); i++) begin
				if (bus_i.sel[i])
					mem[word_idx][8*i +: 8] <= bus_i.dat_w[8*i +: 8];
			end
		end
		bus_i.dat_r <= mem[word_idx];
	end

	// Single-cycle ack, then low while stb is still held
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= bus_i.cyc & bus_i.stb & ~ack_q;
	end

	assign bus_i.ack = ack_q;

endmodule

//--- source/csr_bridge.sv
// Wishbone to CSR bus bridge returning the OR of all bank read data
`timescale 1ns/1ps

module csr_bridge (
	input  logic                   sys_clk,
	input  logic                   sys_rst_i,
	input  soc_map_pkg::wb_data_t  dr_sysctl_i,
	input  soc_map_pkg::wb_data_t  dr_timer_i,
	wb_slave_if.slave              bus_i,
	output soc_csr_pkg::csr_addr_t csr_a_o,
	output logic                   csr_we_o,
	output soc_map_pkg::wb_data_t  csr_dw_o
);
	import soc_map_pkg::*;
	import soc_csr_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_REPLY} state_t;

	state_t    state;
	csr_addr_t acc_adr;
	wb_data_t  rd_or;

	// CSR word address from bus bits 15..2
	assign acc_adr = bus_i.adr[$bits(csr_addr_t)+1:2];

	// ------------------------------------------------------------
	// Access FSM
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= ST_IDLE;
			csr_a_o <= '0;
			csr_we_o <= 1'b0;
		end else begin
			// Address and strobe live for one cycle only
			csr_a_o <= '0;
			csr_we_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (bus_i.cyc && bus_i.stb) begin
						csr_a_o <= acc_adr;
						csr_we_o <= bus_i.we;
						state <= ST_ACCESS;
					end
				end
				// Banks register their read data here
				ST_ACCESS: state <= ST_REPLY;
				// Ack cycle
				ST_REPLY: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Write data captured together with the address
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE && bus_i.cyc && bus_i.stb)
			csr_dw_o <= bus_i.dat_w;
	end

	// Non-matching banks drive zero
	assign rd_or = dr_sysctl_i | dr_timer_i;
	assign bus_i.dat_r = rd_or;
	assign bus_i.ack = state == ST_REPLY;

endmodule

//--- source/sysctl_gpio.sv
// System controller bank with GPIO, bus-error enable and hard reset
`timescale 1ns/1ps

module sysctl_gpio (
	input  logic                            sys_clk,
	input  logic                            sys_rst_i,
	input  soc_csr_pkg::csr_addr_t          csr_a_i,
	input  logic                            csr_we_i,
	input  soc_map_pkg::wb_data_t           csr_dw_i,
	input  logic [soc_csr_pkg::NUM_BTN-1:0] btn_i,
	output soc_map_pkg::wb_data_t           csr_dr_o,
	output logic [soc_csr_pkg::NUM_LED-1:0] led_o,
	output logic                            bus_err_en_o,
	output logic                            hard_reset_o,
	output logic                            irq_o
);
	import soc_map_pkg::*;
	import soc_csr_pkg::*;

	csr_bank_t          bank;
	csr_reg_t           reg_sel;
	logic               bank_hit;
	logic [NUM_BTN-1:0] btn_meta;
	logic [NUM_BTN-1:0] btn_sync;
	logic [NUM_BTN-1:0] btn_prev;
	logic [NUM_BTN-1:0] irq_en;

	assign bank = csr_a_i[$bits(csr_addr_t)-1 -: $bits(csr_bank_t)];
	assign reg_sel = csr_a_i[$bits(csr_reg_t)-1:0];
	assign bank_hit = bank == BANK_SYSCTL;

	// Two-stage button sync, plus one stage for edge detect
	always_ff @(posedge sys_clk) begin
		btn_meta <= btn_i;
		btn_sync <= btn_meta;
		btn_prev <= btn_sync;
	end

	// ------------------------------------------------------------
	// Registers and read port
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			led_o <= '0;
			irq_en <= '0;
			bus_err_en_o <= 1'b0;
			hard_reset_o <= 1'b0;
			irq_o <= 1'b0;
			csr_dr_o <= '0;
		end else begin
			hard_reset_o <= 1'b0;
			// Any change on an enabled input
			irq_o <= |((btn_sync ^ btn_prev) & irq_en);
			if (csr_we_i && bank_hit) begin
				case (reg_sel)
					REG_GPIO_OUT: led_o <= csr_dw_i[NUM_LED-1:0];
					REG_GPIO_IRQ_EN: irq_en <= csr_dw_i[NUM_BTN-1:0];
					REG_BUS_ERR_EN: bus_err_en_o <= csr_dw_i[0];
					// Data ignored, any write resets
					REG_HARD_RESET: hard_reset_o <= 1'b1;
					default: ;
				endcase
			end
			// Zero unless this bank is addressed
			csr_dr_o <= '0;
			if (bank_hit) begin
				case (reg_sel)
					REG_GPIO_IN: csr_dr_o <= wb_data_t'(btn_sync);
					REG_GPIO_OUT: csr_dr_o <= wb_data_t'(led_o);
					REG_GPIO_IRQ_EN: csr_dr_o <= wb_data_t'(irq_en);
					REG_BUS_ERR_EN: csr_dr_o <= wb_data_t'(bus_err_en_o);
					default: ;
				endcase
			end
		end
	end

endmodule

//--- source/sysctl_timer.sv
// Compare timer CSR bank with one-shot or autoreload interrupt
`timescale 1ns/1ps

module sysctl_timer (
	input  logic                   sys_clk,
	input  logic                   sys_rst_i,
	input  soc_csr_pkg::csr_addr_t csr_a_i,
	input  logic                   csr_we_i,
	input  soc_map_pkg::wb_data_t  csr_dw_i,
	output soc_map_pkg::wb_data_t  csr_dr_o,
	output logic                   irq_o
);
	import soc_map_pkg::*;
	import soc_csr_pkg::*;

	csr_bank_t bank;
	csr_reg_t  reg_sel;
	logic      bank_hit;
	logic      en;
	logic      autoreload;
	wb_data_t  compare;
	wb_data_t  counter;
	wb_data_t  ctrl_word;

	assign bank = csr_a_i[$bits(csr_addr_t)-1 -: $bits(csr_bank_t)];
	assign reg_sel = csr_a_i[$bits(csr_reg_t)-1:0];
	assign bank_hit = bank == BANK_TIMER;

	// Control register view
	always_comb begin
		ctrl_word = '0;
		ctrl_word[TMR_CTRL_EN] = en;
		ctrl_word[TMR_CTRL_AUTORELOAD] = autoreload;
	end

	// ------------------------------------------------------------
	// Counter and control
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			en <= 1'b0;
			autoreload <= 1'b0;
			counter <= '0;
			irq_o <= 1'b0;
			csr_dr_o <= '0;
		end else begin
			irq_o <= 1'b0;
			if (en) begin
				if (counter == compare) begin
					counter <= '0;
					irq_o <= 1'b1;
					// One-shot stops itself
					if (!autoreload)
						en <= 1'b0;
				end else begin
					counter <= counter + 1'b1;
				end
			end
			// Bus writes take priority
			if (csr_we_i && bank_hit) begin
				case (reg_sel)
					REG_TMR_CTRL: begin
						en <= csr_dw_i[TMR_CTRL_EN];
						autoreload <= csr_dw_i[TMR_CTRL_AUTORELOAD];
					end
					REG_TMR_COUNTER: counter <= csr_dw_i;
					default: ;
				endcase
			end
			csr_dr_o <= '0;
			if (bank_hit) begin
				case (reg_sel)
					REG_TMR_CTRL: csr_dr_o <= ctrl_word;
					REG_TMR_COMPARE: csr_dr_o <= compare;
					REG_TMR_COUNTER: csr_dr_o <= counter;
					default: ;
				endcase
			end
		end
	end

	// Compare value
	always_ff @(posedge sys_clk) begin
		if (csr_we_i && bank_hit && reg_sel == REG_TMR_COMPARE)
			compare <= csr_dw_i;
	end

endmodule

//--- source/soc_top.sv
// SoC top level joining reset, decoder, boot memory and CSR banks
`timescale 1ns/1ps

module soc_top (
	input  logic                            sys_clk,
	input  logic                            trigger_reset,
	input  soc_map_pkg::wb_addr_t           wb_adr_i,
	input  soc_map_pkg::wb_data_t           wb_dat_i,
	input  soc_map_pkg::wb_sel_t            wb_sel_i,
	input  logic                            wb_we_i,
	input  logic                            wb_cyc_i,
	input  logic                            wb_stb_i,
	input  logic [soc_csr_pkg::NUM_BTN-1:0] btn_i,
	output soc_map_pkg::wb_data_t           wb_dat_o,
	output logic                            wb_ack_o,
	output logic                            wb_err_o,
	output logic [soc_csr_pkg::NUM_LED-1:0] led_o,
	output logic [soc_map_pkg::NUM_IRQ-1:0] irq_o
);
	import soc_map_pkg::*;
	import soc_csr_pkg::*;

	logic      sys_rst;
	logic      bus_err_en;
	logic      hard_reset;
	csr_addr_t csr_a;
	logic      csr_we;
	wb_data_t  csr_dw;
	wb_data_t  csr_dr_sysctl;
	wb_data_t  csr_dr_timer;

	wb_slave_if ram_bus ();
	wb_slave_if csr_bus ();

	// ------------------------------------------------------------
	// Reset and bus
	// ------------------------------------------------------------
	reset_gen reset_gen_i (
		.sys_clk(sys_clk), .trigger_reset(trigger_reset), .btn_i(btn_i),
		.hard_reset_i(hard_reset), .sys_rst_o(sys_rst)
	);

	wb_decoder wb_decoder_i (
		.sys_clk(sys_clk), .sys_rst_i(sys_rst),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
		.wb_we_i(wb_we_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
		.bus_err_en_i(bus_err_en),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o),
		.ram_o(ram_bus.decoder), .csr_o(csr_bus.decoder)
	);

	boot_ram boot_ram_i (.sys_clk(sys_clk), .sys_rst_i(sys_rst), .bus_i(ram_bus.slave));

	// CSR side
	csr_bridge csr_bridge_i (
		.sys_clk(sys_clk), .sys_rst_i(sys_rst),
		.dr_sysctl_i(csr_dr_sysctl), .dr_timer_i(csr_dr_timer),
		.bus_i(csr_bus.slave),
		.csr_a_o(csr_a), .csr_we_o(csr_we), .csr_dw_o(csr_dw)
	);

	sysctl_gpio sysctl_gpio_i (
		.sys_clk(sys_clk), .sys_rst_i(sys_rst),
		.csr_a_i(csr_a), .csr_we_i(csr_we), .csr_dw_i(csr_dw), .btn_i(btn_i),
		.csr_dr_o(csr_dr_sysctl), .led_o(led_o), .bus_err_en_o(bus_err_en),
		.hard_reset_o(hard_reset), .irq_o(irq_o[IRQ_GPIO])
	);

	sysctl_timer sysctl_timer_i (
		.sys_clk(sys_clk), .sys_rst_i(sys_rst),
		.csr_a_i(csr_a), .csr_we_i(csr_we), .csr_dw_i(csr_dw),
		.csr_dr_o(csr_dr_timer), .irq_o(irq_o[IRQ_TIMER])
	);

endmodule

//--- test/clk_gen.sv
// Free-running clock source for the SoC testbench
`timescale 1ns/1ps

module clk_gen #(
	parameter int PERIOD_NS = 100
) (
	output logic clk_o
);

	// Low for the first half period, then toggles forever
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

endmodule

//--- test/tb_soc.sv
// Testbench for the SoC slice with random bus traffic and a reference model
`timescale 1ns/1ps

module tb_soc;
	import soc_map_pkg::*;
	import soc_csr_pkg::*;

	localparam int ACK_TIMEOUT = 20;
	localparam int IRQ_TIMEOUT = 10;
	localparam int RST_TIMEOUT = RST_HOLD_CYCLES + 50;
	localparam int unsigned SEED = 32'h9c79;
	// Unmapped probe address in region 001
	localparam wb_addr_t PROBE_ADR = 32'h1000_0000;

	logic               sys_clk;
	logic               trigger_reset;
	wb_addr_t           wb_adr;
	wb_data_t           wb_dat_w;
	wb_sel_t            wb_sel;
	logic               wb_we;
	logic               wb_cyc;
	logic               wb_stb;
	logic [NUM_BTN-1:0] btn;
	wb_data_t           wb_dat_r;
	logic               wb_ack;
	logic               wb_err;
	logic [NUM_LED-1:0] led;
	logic [NUM_IRQ-1:0] irq;

	// Reference model state
	wb_data_t           ram_m [2**RAM_ADDR_WIDTH];
	logic [NUM_LED-1:0] led_m;
	logic [NUM_BTN-1:0] irq_en_m;
	logic               bus_err_en_m;
	wb_data_t           compare_m;

	// Scratch stimulus
	wb_data_t           rd;
	wb_data_t           dat;
	wb_addr_t           adr;
	wb_sel_t            sel;
	ram_addr_t          idx;
	logic               shadow;
	logic [NUM_BTN-1:0] btn_next;

	int value_errors;
	int timeouts;

	clk_gen #(.PERIOD_NS(100)) clk_gen_i (.clk_o(sys_clk));

	soc_top soc_top_i (
		.sys_clk(sys_clk), .trigger_reset(trigger_reset),
		.wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_sel_i(wb_sel),
		.wb_we_i(wb_we), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .btn_i(btn),
		.wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack), .wb_err_o(wb_err),
		.led_o(led), .irq_o(irq)
	);

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	task automatic mismatch(input string name, input wb_data_t got, input wb_data_t exp);
		value_errors++;
		$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
	endtask

	// Bit mask of the selected byte lanes
	function automatic wb_data_t lane_mask(input wb_sel_t sel_in);
		wb_data_t m;
		for (int b = 0; b < $bits(wb_sel_t); b++)
			m[8*b +: 8] = {8{sel_in[b]}};
		return m;
	endfunction

	// Region 0 word address with random alias bits above the index
	function automatic wb_addr_t ram_addr(input ram_addr_t word, input logic shadow_in);
		wb_addr_t a;
		a = $urandom;
		a[31] = shadow_in;
		a[30:28] = REGION_BOOT;
		a[RAM_ADDR_WIDTH+1:2] = word;
		a[1:0] = 2'b00;
		return a;
	endfunction

	function automatic wb_addr_t csr_addr(input csr_bank_t bank, input csr_reg_t offs);
		wb_addr_t a;
		a = '0;
		a[30:29] = REGION_CSR;
		a[15:2] = {bank, offs};
		return a;
	endfunction

	// One classic cycle held until ack
	// Error flag expected on ack when enabled and top 14 address bits are zero
	task automatic bus_access(input wb_addr_t a, input logic we, input wb_data_t d,
			input wb_sel_t s, output wb_data_t rdat);
		int   n;
		logic err_exp;
		n = 0;
		err_exp = bus_err_en_m && (a[31 -: LOCK_TOP_BITS] == '0);
		@(negedge sys_clk);
		wb_adr = a;
		wb_dat_w = d;
		wb_sel = s;
		wb_we = we;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		do begin
			@(negedge sys_clk);
			n++;
		end while (wb_ack !== 1'b1 && n < ACK_TIMEOUT);
		rdat = wb_dat_r;
		if (wb_ack !== 1'b1) begin
			timeouts++;
			$display("Timeout: no ack for access to address %h", a);
		end else if (wb_err !== err_exp) begin
			mismatch("wb_err_o", wb_err, err_exp);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic csr_write(input csr_bank_t bank, input csr_reg_t offs, input wb_data_t d);
		wb_data_t ignored;
		bus_access(csr_addr(bank, offs), 1'b1, d, 4'hf, ignored);
	endtask

	task automatic csr_read(input csr_bank_t bank, input csr_reg_t offs, output wb_data_t d);
		bus_access(csr_addr(bank, offs), 1'b0, '0, 4'hf, d);
	endtask

	// Unmapped read kept pending until reset is gone
	task automatic await_reset_release();
		int n;
		n = 0;
		@(negedge sys_clk);
		wb_adr = PROBE_ADR;
		wb_sel = 4'hf;
		wb_we = 1'b0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		do begin
			@(negedge sys_clk);
			n++;
		end while (wb_ack !== 1'b1 && n < RST_TIMEOUT);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		if (wb_ack !== 1'b1) begin
			timeouts++;
			$display("Timeout: system reset still active after %0d cycles", RST_TIMEOUT);
		end else if (n < RST_HOLD_CYCLES) begin
			value_errors++;
			$display("Reset released after %0d cycles, shorter than the hold time", n);
		end else if (wb_dat_r !== '0) begin
			mismatch("wb_dat_o", wb_dat_r, '0);
		end
	endtask

	// Polled on falling edges since irq lines are registered
	task automatic await_irq(input int irq_idx, input int limit);
		int n;
		n = 0;
		while (irq[irq_idx] !== 1'b1 && n < limit) begin
			@(negedge sys_clk);
			n++;
		end
		if (irq[irq_idx] !== 1'b1) begin
			timeouts++;
			$display("Timeout: interrupt %0d did not pulse within %0d cycles", irq_idx, limit);
		end
	endtask

	// LEDs and error enable set for a reset to clear
	task automatic arm_sysctl();
		led_m = $urandom_range(1, 3);
		csr_write(BANK_SYSCTL, REG_GPIO_OUT, wb_data_t'(led_m));
		csr_write(BANK_SYSCTL, REG_BUS_ERR_EN, 32'h1);
		bus_err_en_m = 1'b1;
	endtask

	task automatic check_cleared();
		led_m = '0;
		irq_en_m = '0;
		bus_err_en_m = 1'b0;
		if (led !== '0)
			mismatch("led_o", led, '0);
		csr_read(BANK_SYSCTL, REG_GPIO_OUT, rd);
		if (rd !== '0)
			mismatch("REG_GPIO_OUT", rd, '0);
		csr_read(BANK_SYSCTL, REG_BUS_ERR_EN, rd);
		if (rd !== '0)
			mismatch("REG_BUS_ERR_EN", rd, '0);
		csr_read(BANK_SYSCTL, REG_GPIO_IRQ_EN, rd);
		if (rd !== '0)
			mismatch("REG_GPIO_IRQ_EN", rd, '0);
	endtask

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial begin
		value_errors = 0;
		timeouts = 0;
		// Seed once
		rd = $urandom(SEED);
		trigger_reset = 1'b1;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = '0;
		wb_we = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		btn = '0;
		led_m = '0;
		irq_en_m = '0;
		bus_err_en_m = 1'b0;
		// Trigger seen on four rising edges
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		trigger_reset = 1'b0;
		await_reset_release();

		// Whole boot memory written first so every read is defined
		for (int i = 0; i < 2**RAM_ADDR_WIDTH; i++) begin
			ram_m[i] = $urandom;
			bus_access(ram_addr(ram_addr_t'(i), 1'b0), 1'b1, ram_m[i], 4'hf, rd);
		end
		// Mixed traffic with shadow alias and partial lanes
		for (int i = 0; i < 120; i++) begin
			idx = $urandom;
			sel = $urandom;
			dat = $urandom;
			shadow = $urandom;
			if ($urandom_range(0, 1) == 1) begin
				bus_access(ram_addr(idx, shadow), 1'b1, dat, sel, rd);
				ram_m[idx] = (ram_m[idx] & ~lane_mask(sel)) | (dat & lane_mask(sel));
			end else begin
				bus_access(ram_addr(idx, shadow), 1'b0, '0, 4'hf, rd);
				if (rd !== ram_m[idx])
					mismatch("wb_dat_o", rd, ram_m[idx]);
			end
		end
		for (int i = 0; i < 2**RAM_ADDR_WIDTH; i++) begin
			bus_access(ram_addr(ram_addr_t'(i), 1'b1), 1'b0, '0, 4'hf, rd);
			if (rd !== ram_m[i])
				mismatch("wb_dat_o", rd, ram_m[i]);
		end

		// GPIO outputs
		for (int i = 0; i < 8; i++) begin
			dat = $urandom;
			csr_write(BANK_SYSCTL, REG_GPIO_OUT, dat);
			led_m = dat[NUM_LED-1:0];
			if (led !== led_m)
				mismatch("led_o", led, led_m);
			csr_read(BANK_SYSCTL, REG_GPIO_OUT, rd);
			if (rd !== wb_data_t'(led_m))
				mismatch("REG_GPIO_OUT", rd, led_m);
		end
		// Synchronized inputs without all three buttons down
		for (int i = 0; i < 6; i++) begin
			@(negedge sys_clk);
			btn = $urandom_range(0, 6);
			repeat (4) @(negedge sys_clk);
			csr_read(BANK_SYSCTL, REG_GPIO_IN, rd);
			if (rd !== wb_data_t'(btn))
				mismatch("REG_GPIO_IN", rd, btn);
		end
		irq_en_m = '1;
		csr_write(BANK_SYSCTL, REG_GPIO_IRQ_EN, wb_data_t'(irq_en_m));
		csr_read(BANK_SYSCTL, REG_GPIO_IRQ_EN, rd);
		if (rd !== wb_data_t'(irq_en_m))
			mismatch("REG_GPIO_IRQ_EN", rd, irq_en_m);
		// Each input change must pulse the GPIO line
		for (int i = 0; i < 4; i++) begin
			do btn_next = $urandom_range(0, 6); while (btn_next == btn);
			@(negedge sys_clk);
			btn = btn_next;
			await_irq(IRQ_GPIO, IRQ_TIMEOUT);
			repeat (3) @(negedge sys_clk);
		end

		// Unmapped regions 001 to 101 on bits 30..28
		for (int i = 0; i < 6; i++) begin
			adr = $urandom;
			adr[30:28] = $urandom_range(1, 5);
			bus_access(adr, $urandom_range(0, 1), $urandom, 4'hf, rd);
			if (rd !== '0)
				mismatch("wb_dat_o", rd, '0);
		end
		// Error flag enabled so only the null area is flagged
		csr_write(BANK_SYSCTL, REG_BUS_ERR_EN, 32'h1);
		bus_err_en_m = 1'b1;
		csr_read(BANK_SYSCTL, REG_BUS_ERR_EN, rd);
		if (rd !== 32'h1)
			mismatch("REG_BUS_ERR_EN", rd, 32'h1);
		for (int i = 0; i < 6; i++) begin
			idx = $urandom;
			bus_access({22'h0, idx, 2'b00}, 1'b0, '0, 4'hf, rd);
			if (rd !== ram_m[idx])
				mismatch("wb_dat_o", rd, ram_m[idx]);
			bus_access(ram_addr(idx, 1'b1), 1'b0, '0, 4'hf, rd);
			if (rd !== ram_m[idx])
				mismatch("wb_dat_o", rd, ram_m[idx]);
			csr_read(BANK_SYSCTL, REG_GPIO_OUT, rd);
		end
		csr_write(BANK_SYSCTL, REG_BUS_ERR_EN, 32'h0);
		bus_err_en_m = 1'b0;
		bus_access({22'h0, idx, 2'b00}, 1'b0, '0, 4'hf, rd);

		// One-shot timer
		for (int i = 0; i < 3; i++) begin
			compare_m = $urandom_range(4, 40);
			csr_write(BANK_TIMER, REG_TMR_COUNTER, 32'h0);
			csr_write(BANK_TIMER, REG_TMR_COMPARE, compare_m);
			csr_read(BANK_TIMER, REG_TMR_COMPARE, rd);
			if (rd !== compare_m)
				mismatch("REG_TMR_COMPARE", rd, compare_m);
			dat = '0;
			dat[TMR_CTRL_EN] = 1'b1;
			csr_write(BANK_TIMER, REG_TMR_CTRL, dat);
			await_irq(IRQ_TIMER, int'(compare_m) + IRQ_TIMEOUT);
			// Enable drops by itself without autoreload
			csr_read(BANK_TIMER, REG_TMR_CTRL, rd);
			if (rd !== '0)
				mismatch("REG_TMR_CTRL", rd, '0);
			csr_read(BANK_TIMER, REG_TMR_COUNTER, rd);
			if (rd !== '0)
				mismatch("REG_TMR_COUNTER", rd, '0);
		end

		// Software hard reset
		arm_sysctl();
		csr_write(BANK_SYSCTL, REG_HARD_RESET, $urandom);
		bus_err_en_m = 1'b0;
		await_reset_release();
		check_cleared();
		// All three buttons at once
		arm_sysctl();
		@(negedge sys_clk);
		btn = '1;
		repeat (2) @(negedge sys_clk);
		btn = '0;
		bus_err_en_m = 1'b0;
		await_reset_release();
		check_cleared();

		$display("Value errors: %0d, timeouts: %0d", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- list.f
source/soc_map_pkg.sv
source/soc_csr_pkg.sv
source/wb_slave_if.sv
source/reset_gen.sv
source/wb_decoder.sv
source/boot_ram.sv
source/csr_bridge.sv
source/sysctl_gpio.sv
source/sysctl_timer.sv
source/soc_top.sv
test/clk_gen.sv
test/tb_soc.sv

//--- Bender.yml
package:
  name: soc_slice

sources:
  - source/soc_map_pkg.sv
  - source/soc_csr_pkg.sv
  - source/wb_slave_if.sv
  - source/reset_gen.sv
  - source/wb_decoder.sv
  - source/boot_ram.sv
  - source/csr_bridge.sv
  - source/sysctl_gpio.sv
  - source/sysctl_timer.sv
  - source/soc_top.sv
  - target: test
    files:
      - test/clk_gen.sv
      - test/tb_soc.sv
